// ==== src/sdmac_bus_pkg.sv ====
// SDMAC register block, bus side definitions
// CPU address map, action opcodes and termination states
`default_nettype none

package sdmac_bus_pkg;

  localparam int ADDR_W    = 8;   // CPU address width
  localparam int DATA_W    = 32;  // Data bus width
  localparam int CH_LSB    = 5;   // Channel index in addr[7:5]
  localparam int CH_IDX_W  = 3;
  localparam int OFS_LSB   = 2;   // Register offset in addr[4:2]
  localparam int OFS_W     = 3;
  localparam int WTC_VALUE = 4;   // Fixed word transfer count

  // Register offsets within a channel window
  localparam logic [OFS_W-1:0] OFS_WTC     = 3'd0;
  localparam logic [OFS_W-1:0] OFS_CNTR    = 3'd1;
  localparam logic [OFS_W-1:0] OFS_ISTR    = 3'd2;
  localparam logic [OFS_W-1:0] OFS_ACR     = 3'd3;
  localparam logic [OFS_W-1:0] OFS_ST_DMA  = 3'd4;
  localparam logic [OFS_W-1:0] OFS_SP_DMA  = 3'd5;
  localparam logic [OFS_W-1:0] OFS_CLR_INT = 3'd6;
  localparam logic [OFS_W-1:0] OFS_FLUSH   = 3'd7;

  // One action per accepted bus cycle
  typedef enum logic [3:0] {
    OP_NONE    = 4'd0,
    OP_WTC_RD  = 4'd1,  // Read, offset 0
    OP_CNTR_RD = 4'd2,  // Read, offset 1
    OP_CNTR_WR = 4'd3,  // Write, offset 1
    OP_ISTR_RD = 4'd4,  // Read, offset 2
    OP_ACR_WR  = 4'd5,  // Write, offset 3
    OP_ST_DMA  = 4'd6,  // Strobes, either direction
    OP_SP_DMA  = 4'd7,
    OP_CLR_INT = 4'd8,
    OP_FLUSH   = 4'd9
  } reg_op_e;

  // DSACK termination FSM
  typedef enum logic [1:0] {
    T_IDLE = 2'd0,
    T_WAIT = 2'd1,  // CPU has seen dsack_, as_ still low
    T_ACK  = 2'd2
  } term_state_e;

endpackage

`default_nettype wire

// ==== src/sdmac_chan_pkg.sv ====
// SDMAC register block, channel side definitions
// Register widths and bit positions of CNTR and ISTR
`default_nettype none

package sdmac_chan_pkg;

  localparam int CNTR_W = 9;  // Control register width
  localparam int ISTR_W = 9;  // Interrupt status register width

  // Control register bits
  localparam int CNTR_DDIR   = 1;  // DMA direction
  localparam int CNTR_INTEN  = 2;  // Interrupt enable
  localparam int CNTR_PRESET = 4;  // Peripheral reset
  localparam int CNTR_DMAENA = 8;  // Read only, mirrors the enable flag

  // Bits 0..7 are CPU writable
  localparam logic [CNTR_W-1:0] CNTR_WR_MASK = 9'h0FF;

  // Status register bits, the rest read zero
  localparam int ISTR_FE    = 0;  // FIFO empty, live
  localparam int ISTR_FF    = 1;  // FIFO full, live
  localparam int ISTR_INT_P = 4;  // Interrupt pending, latched
  localparam int ISTR_INTS  = 5;  // Interrupt input, live

  // Write data bit kept by an ACR write
  localparam int A1_BIT = 25;

endpackage

`default_nettype wire

// ==== src/sdmac_addr_decoder.sv ====
// SDMAC address decoder
// Detects the start of a CPU bus cycle and issues one action opcode
// plus a one-hot channel select for the following clock
`timescale 1ns/1ps
`default_nettype none

module sdmac_addr_decoder #(
  parameter int NUM_CH = 4
) (
  input  wire                                  ACR_WR,
  input  wire                                  RST_,
  input  wire  [sdmac_bus_pkg::ADDR_W-1:0]     addr,
  input  wire                                  sel_,   // Chip select
  input  wire                                  as_,    // Address strobe
  input  wire                                  rw,     // 1 = read
  input  wire  [sdmac_bus_pkg::DATA_W-1:0]     mid,
  output sdmac_bus_pkg::reg_op_e               op,
  output logic                                 cyc,    // Accepted cycle, one clock
  output logic [NUM_CH-1:0]                    ch_sel,
  output logic [sdmac_bus_pkg::CH_IDX_W-1:0]   ch_idx,
  output logic [sdmac_bus_pkg::DATA_W-1:0]     wdata
);

  logic                                as_q;      // Previous as_ sample
  logic                                start;
  logic                                in_range;
  logic [sdmac_bus_pkg::CH_IDX_W-1:0]  ch_d;
  logic [sdmac_bus_pkg::OFS_W-1:0]     ofs_d;
  logic [NUM_CH-1:0]                   sel_d;
  sdmac_bus_pkg::reg_op_e              op_d;

  assign ch_d     = addr[sdmac_bus_pkg::CH_LSB +: sdmac_bus_pkg::CH_IDX_W];
  assign ofs_d    = addr[sdmac_bus_pkg::OFS_LSB +: sdmac_bus_pkg::OFS_W];
  assign in_range = int'(ch_d) < NUM_CH;
  assign start    = ~as_ & as_q & ~sel_;  // Falling as_ with chip selected

  // Offset and direction to action
  always_comb begin
    case (ofs_d)
      sdmac_bus_pkg::OFS_WTC:     op_d = rw ? sdmac_bus_pkg::OP_WTC_RD : sdmac_bus_pkg::OP_NONE;
      sdmac_bus_pkg::OFS_CNTR:    op_d = rw ? sdmac_bus_pkg::OP_CNTR_RD : sdmac_bus_pkg::OP_CNTR_WR;
      sdmac_bus_pkg::OFS_ISTR:    op_d = rw ? sdmac_bus_pkg::OP_ISTR_RD : sdmac_bus_pkg::OP_NONE;
      sdmac_bus_pkg::OFS_ACR:     op_d = rw ? sdmac_bus_pkg::OP_NONE : sdmac_bus_pkg::OP_ACR_WR;
      sdmac_bus_pkg::OFS_ST_DMA:  op_d = sdmac_bus_pkg::OP_ST_DMA;
      sdmac_bus_pkg::OFS_SP_DMA:  op_d = sdmac_bus_pkg::OP_SP_DMA;
      sdmac_bus_pkg::OFS_CLR_INT: op_d = sdmac_bus_pkg::OP_CLR_INT;
      sdmac_bus_pkg::OFS_FLUSH:   op_d = sdmac_bus_pkg::OP_FLUSH;
      default:                    op_d = sdmac_bus_pkg::OP_NONE;
    endcase
    if (!in_range) op_d = sdmac_bus_pkg::OP_NONE;  // No such channel
  end

  // Channel index to one-hot, all zero when out of range
  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      sel_d[i] = (int'(ch_d) == i);
    end
  end

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      as_q   <= 1'b1;
      op     <= sdmac_bus_pkg::OP_NONE;
      cyc    <= 1'b0;
      ch_sel <= '0;
    end else begin
      as_q   <= as_;
      op     <= start ? op_d : sdmac_bus_pkg::OP_NONE;  // Single clock action
      cyc    <= start;
      ch_sel <= start ? sel_d : '0;
    end
  end

  // Payload, only read alongside op
  always_ff @(posedge ACR_WR) begin
    if (start) begin
      ch_idx <= ch_d;
      wdata  <= mid;
    end
  end

endmodule

`default_nettype wire

// ==== src/sdmac_channel_regs.sv ====
// SDMAC channel register slice
// Control, interrupt status, DMA enable, FIFO flush and A1 state of one channel
`timescale 1ns/1ps
`default_nettype none

module sdmac_channel_regs (
  input  wire                                ACR_WR,
  input  wire                                RST_,
  input  sdmac_bus_pkg::reg_op_e             op,
  input  wire                                sel,         // This channel addressed
  input  wire  [sdmac_bus_pkg::DATA_W-1:0]   wdata,
  input  wire                                fifo_empty,
  input  wire                                fifo_full,
  input  wire                                inta_i,      // Peripheral interrupt
  input  wire                                stop_flush,
  output logic [sdmac_chan_pkg::CNTR_W-1:0]  cntr_q,
  output logic [sdmac_chan_pkg::ISTR_W-1:0]  istr_q,
  output logic                               int_req,
  output logic                               dmadir,
  output logic                               dmaena,
  output logic                               preset,
  output logic                               flush_fifo,
  output logic                               a1
);

  logic [sdmac_chan_pkg::CNTR_W-1:0] cntr_r;  // Writable part only
  logic                              int_p;   // Latched interrupt
  logic                              clr_int;

  assign clr_int = sel && (op == sdmac_bus_pkg::OP_CLR_INT);

  // Control register, DMA enable and A1
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      cntr_r <= '0;
      dmaena <= 1'b0;
      a1     <= 1'b0;
    end else if (sel) begin
      case (op)
        sdmac_bus_pkg::OP_CNTR_WR:
          cntr_r <= wdata[sdmac_chan_pkg::CNTR_W-1:0] & sdmac_chan_pkg::CNTR_WR_MASK;
        sdmac_bus_pkg::OP_ST_DMA:
          dmaena <= 1'b1;
        sdmac_bus_pkg::OP_SP_DMA:
          dmaena <= 1'b0;
        sdmac_bus_pkg::OP_ACR_WR:
          a1 <= wdata[sdmac_chan_pkg::A1_BIT];
        default: ;  // Reads and other strobes leave these alone
      endcase
    end
  end

  // Interrupt pending, clear wins over a new request
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      int_p <= 1'b0;
    end else if (clr_int) begin
      int_p <= 1'b0;
    end else if (inta_i) begin
      int_p <= 1'b1;
    end
  end

  // FIFO flush latch, stop_flush first
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      flush_fifo <= 1'b0;
    end else if (stop_flush) begin
      flush_fifo <= 1'b0;
    end else if (sel && (op == sdmac_bus_pkg::OP_FLUSH)) begin
      flush_fifo <= 1'b1;
    end
  end

  // CNTR readback with enable mirror in bit 8
  always_comb begin
    cntr_q = cntr_r & sdmac_chan_pkg::CNTR_WR_MASK;
    cntr_q[sdmac_chan_pkg::CNTR_DMAENA] = dmaena;
  end

  // ISTR, live FIFO flags and interrupt input
  always_comb begin
    istr_q = '0;
    istr_q[sdmac_chan_pkg::ISTR_FE]    = fifo_empty;
    istr_q[sdmac_chan_pkg::ISTR_FF]    = fifo_full;
    istr_q[sdmac_chan_pkg::ISTR_INT_P] = int_p;
    istr_q[sdmac_chan_pkg::ISTR_INTS]  = inta_i;
  end

  assign int_req = int_p & cntr_r[sdmac_chan_pkg::CNTR_INTEN];  // Masked request
  assign dmadir  = cntr_r[sdmac_chan_pkg::CNTR_DDIR];
  assign preset  = cntr_r[sdmac_chan_pkg::CNTR_PRESET];

endmodule

`default_nettype wire

// ==== src/sdmac_bus_return.sv ====
// SDMAC bus return path
// Read data mux into mod, interrupt combine and DSACK termination FSM
`timescale 1ns/1ps
`default_nettype none

module sdmac_bus_return #(
  parameter int NUM_CH = 4
) (
  input  wire                                        ACR_WR,
  input  wire                                        RST_,
  input  wire                                        as_,
  input  sdmac_bus_pkg::reg_op_e                     op,
  input  wire                                        cyc,
  input  wire  [sdmac_bus_pkg::CH_IDX_W-1:0]         ch_idx,
  input  wire  [NUM_CH*sdmac_chan_pkg::CNTR_W-1:0]   cntr_all,
  input  wire  [NUM_CH*sdmac_chan_pkg::ISTR_W-1:0]   istr_all,
  input  wire  [NUM_CH-1:0]                          int_req_all,
  output logic [sdmac_bus_pkg::DATA_W-1:0]           mod,
  output logic                                       dsack_,
  output logic                                       int_o_
);

  sdmac_bus_pkg::term_state_e          state;
  sdmac_bus_pkg::term_state_e          state_d;
  logic [sdmac_bus_pkg::DATA_W-1:0]    rd_val;
  logic [sdmac_chan_pkg::CNTR_W-1:0]   cntr_sel;
  logic [sdmac_chan_pkg::ISTR_W-1:0]   istr_sel;

  // Addressed channel, zero when out of range
  always_comb begin
    cntr_sel = '0;
    istr_sel = '0;
    if (int'(ch_idx) < NUM_CH) begin
      cntr_sel = cntr_all[int'(ch_idx)*sdmac_chan_pkg::CNTR_W +: sdmac_chan_pkg::CNTR_W];
      istr_sel = istr_all[int'(ch_idx)*sdmac_chan_pkg::ISTR_W +: sdmac_chan_pkg::ISTR_W];
    end
  end

  always_comb begin
    case (op)
      sdmac_bus_pkg::OP_WTC_RD:  rd_val = sdmac_bus_pkg::DATA_W'(sdmac_bus_pkg::WTC_VALUE);
      sdmac_bus_pkg::OP_CNTR_RD: rd_val = sdmac_bus_pkg::DATA_W'(cntr_sel);
      sdmac_bus_pkg::OP_ISTR_RD: rd_val = sdmac_bus_pkg::DATA_W'(istr_sel);
      default:                   rd_val = '0;  // Writes and strobes
    endcase
  end

  // Termination, dsack_ low in T_ACK and T_WAIT
  always_comb begin
    state_d = state;
    case (state)
      sdmac_bus_pkg::T_IDLE: if (cyc) state_d = sdmac_bus_pkg::T_ACK;
      sdmac_bus_pkg::T_ACK:  state_d = as_ ? sdmac_bus_pkg::T_IDLE : sdmac_bus_pkg::T_WAIT;
      sdmac_bus_pkg::T_WAIT: if (as_) state_d = sdmac_bus_pkg::T_IDLE;
      default:               state_d = sdmac_bus_pkg::T_IDLE;
    endcase
  end

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      state  <= sdmac_bus_pkg::T_IDLE;
      dsack_ <= 1'b1;
      mod    <= '0;
    end else begin
      state  <= state_d;
      dsack_ <= (state_d == sdmac_bus_pkg::T_IDLE);
      if (state == sdmac_bus_pkg::T_IDLE && cyc) mod <= rd_val;  // Held until next cycle
    end
  end

  assign int_o_ = ~|int_req_all;  // Active low, any channel

endmodule

`default_nettype wire

// ==== src/sdmac_registers.sv ====
// SDMAC register block top level
// Address decoder, NUM_CH channel slices and the bus return path
`timescale 1ns/1ps
`default_nettype none

module sdmac_registers #(
  parameter int NUM_CH = 4  // 1 to 8
) (
  input  wire                               ACR_WR,
  input  wire                               RST_,
  input  wire  [sdmac_bus_pkg::ADDR_W-1:0]  addr,
  input  wire                               sel_,
  input  wire                               as_,
  input  wire                               rw,
  input  wire  [sdmac_bus_pkg::DATA_W-1:0]  mid,
  input  wire  [NUM_CH-1:0]                 fifo_empty,
  input  wire  [NUM_CH-1:0]                 fifo_full,
  input  wire  [NUM_CH-1:0]                 inta_i,
  input  wire  [NUM_CH-1:0]                 stop_flush,
  output logic [sdmac_bus_pkg::DATA_W-1:0]  mod,
  output logic                              dsack_,
  output logic                              int_o_,
  output logic [NUM_CH-1:0]                 dmadir,
  output logic [NUM_CH-1:0]                 dmaena,
  output logic [NUM_CH-1:0]                 preset,
  output logic [NUM_CH-1:0]                 flush_fifo,
  output logic [NUM_CH-1:0]                 a1
);

  sdmac_bus_pkg::reg_op_e                   op;
  logic                                     cyc;
  logic [NUM_CH-1:0]                        ch_sel;
  logic [sdmac_bus_pkg::CH_IDX_W-1:0]       ch_idx;
  logic [sdmac_bus_pkg::DATA_W-1:0]         wdata;
  logic [NUM_CH*sdmac_chan_pkg::CNTR_W-1:0] cntr_all;  // Flattened per channel
  logic [NUM_CH*sdmac_chan_pkg::ISTR_W-1:0] istr_all;
  logic [NUM_CH-1:0]                        int_req_all;

  if (NUM_CH < 1 || NUM_CH > 8) begin : g_bad_num_ch
    $error("NUM_CH must be 1 to 8");  // Only 3 index bits in addr
  end

  sdmac_addr_decoder #(.NUM_CH(NUM_CH)) u_addr_decoder (
    .ACR_WR (ACR_WR), .RST_ (RST_),
    .addr   (addr),   .sel_ (sel_), .as_ (as_), .rw (rw), .mid (mid),
    .op     (op),     .cyc  (cyc),  .ch_sel (ch_sel),
    .ch_idx (ch_idx), .wdata (wdata)
  );

  for (genvar g = 0; g < NUM_CH; g++) begin : g_chan
    sdmac_channel_regs u_chan (
      .ACR_WR     (ACR_WR),        .RST_       (RST_),
      .op         (op),            .sel        (ch_sel[g]),
      .wdata      (wdata),
      .fifo_empty (fifo_empty[g]), .fifo_full  (fifo_full[g]),
      .inta_i     (inta_i[g]),     .stop_flush (stop_flush[g]),
      .cntr_q     (cntr_all[g*sdmac_chan_pkg::CNTR_W +: sdmac_chan_pkg::CNTR_W]),
      .istr_q     (istr_all[g*sdmac_chan_pkg::ISTR_W +: sdmac_chan_pkg::ISTR_W]),
      .int_req    (int_req_all[g]),
      .dmadir     (dmadir[g]),     .dmaena     (dmaena[g]),
      .preset     (preset[g]),     .flush_fifo (flush_fifo[g]),
      .a1         (a1[g])
    );
  end

  sdmac_bus_return #(.NUM_CH(NUM_CH)) u_bus_return (
    .ACR_WR      (ACR_WR),   .RST_     (RST_),   .as_ (as_),
    .op          (op),       .cyc      (cyc),    .ch_idx (ch_idx),
    .cntr_all    (cntr_all), .istr_all (istr_all),
    .int_req_all (int_req_all),
    .mod         (mod),      .dsack_   (dsack_), .int_o_ (int_o_)
  );

endmodule

`default_nettype wire

// ==== testbench/sdmac_registers_asserts.sv ====
// SDMAC register block assertions
// Strobe, termination and interrupt rules, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module sdmac_registers_asserts #(
  parameter int NUM_CH = 4
) (
  input wire                    ACR_WR,
  input wire                    RST_,
  input wire                    sel_,
  input wire                    as_,
  input wire                    dsack_,
  input wire                    int_o_,
  input sdmac_bus_pkg::reg_op_e op,
  input wire [NUM_CH-1:0]       int_req_all
);

  // One action per accepted cycle
  a_op_single: assert property (@(posedge ACR_WR) disable iff (!RST_)
    op != sdmac_bus_pkg::OP_NONE |=> op == sdmac_bus_pkg::OP_NONE)
    else $error("op active for more than one clock");

  // Falling as_ with chip selected, dsack_ two clocks later
  a_dsack_two: assert property (@(posedge ACR_WR) disable iff (!RST_)
    (!as_ && $past(as_) && !sel_) |-> ##2 $fell(dsack_))
    else $error("dsack_ not asserted two clocks after cycle start");

  a_dsack_release: assert property (@(posedge ACR_WR) disable iff (!RST_)
    as_ |=> dsack_)
    else $error("dsack_ still low after as_ was sampled high");

  a_int_idle: assert property (@(posedge ACR_WR) disable iff (!RST_)
    (int_req_all == '0) |-> int_o_)
    else $error("int_o_ low with no channel request");

endmodule

bind sdmac_registers sdmac_registers_asserts #(.NUM_CH(NUM_CH)) u_asserts (
  .ACR_WR      (ACR_WR),
  .RST_        (RST_),
  .sel_        (sel_),
  .as_         (as_),
  .dsack_      (dsack_),
  .int_o_      (int_o_),
  .op          (op),
  .int_req_all (int_req_all)
);

`default_nettype wire

// ==== testbench/tb_sdmac_registers.sv ====
// SDMAC register block testbench
// Drives CPU bus cycles and checks read data and channel outputs against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_sdmac_registers;

  localparam int NUM_CH    = 4;
  localparam int ACK_LIMIT = 8;  // Clocks allowed per dsack_ edge

  logic              ACR_WR;
  logic              RST_;
  logic [7:0]        addr;
  logic              sel_;
  logic              as_;
  logic              rw;
  logic [31:0]       mid;
  logic [NUM_CH-1:0] fifo_empty;
  logic [NUM_CH-1:0] fifo_full;
  logic [NUM_CH-1:0] inta_i;
  logic [NUM_CH-1:0] stop_flush;
  logic [31:0]       mod;
  logic              dsack_;
  logic              int_o_;
  logic [NUM_CH-1:0] dmadir;
  logic [NUM_CH-1:0] dmaena;
  logic [NUM_CH-1:0] preset;
  logic [NUM_CH-1:0] flush_fifo;
  logic [NUM_CH-1:0] a1;

  logic [7:0]        m_cntr [NUM_CH];  // Model of the writable CNTR bits
  logic [NUM_CH-1:0] m_dmaena;
  logic [NUM_CH-1:0] m_int_p;
  logic [NUM_CH-1:0] m_flush;
  logic [NUM_CH-1:0] m_a1;
  logic [31:0]       lfsr;
  logic [31:0]       exp_mod;           // Expected mod of the cycle in flight
  logic              dsack_prev = 1'b1;
  int                out_req;           // Output check requests
  int                out_done = 0;
  int                n_checks = 0;
  int                err_value = 0;
  int                err_other;

  sdmac_registers #(.NUM_CH(NUM_CH)) u_dut (
    .ACR_WR (ACR_WR), .RST_ (RST_), .addr (addr), .sel_ (sel_), .as_ (as_),
    .rw (rw), .mid (mid), .fifo_empty (fifo_empty), .fifo_full (fifo_full),
    .inta_i (inta_i), .stop_flush (stop_flush), .mod (mod), .dsack_ (dsack_),
    .int_o_ (int_o_), .dmadir (dmadir), .dmaena (dmaena), .preset (preset),
    .flush_fifo (flush_fifo), .a1 (a1)
  );

  initial begin
    ACR_WR = 1'b0;
    forever #5 ACR_WR = ~ACR_WR;
  end

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Expected read data from model state and live inputs
  function automatic logic [31:0] ref_read(input int ch, input int ofs);
    logic [31:0] v;
    v = '0;
    if (ch < NUM_CH) begin
      case (ofs)
        0: v = 32'd4;                          // WTC constant
        1: v = {23'b0, m_dmaena[ch], m_cntr[ch]};
        2: begin
          v[0] = fifo_empty[ch];
          v[1] = fifo_full[ch];
          v[4] = m_int_p[ch];
          v[5] = inta_i[ch];                   // Live INTS
        end
        default: v = '0;                       // Strobes and ACR
      endcase
    end
    return v;
  endfunction

  task automatic update_model(input int ch, input int ofs, input bit rd, input logic [31:0] d);
    if (ch >= NUM_CH) return;
    case (ofs)
      1: if (!rd) m_cntr[ch] = d[7:0];
      3: if (!rd) m_a1[ch] = d[25];
      4: m_dmaena[ch] = 1'b1;
      5: m_dmaena[ch] = 1'b0;
      6: m_int_p[ch] = 1'b0;
      7: m_flush[ch] = 1'b1;
      default: ;
    endcase
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      err_value++;
      $display("error %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
    end
  endtask

  task automatic check_outputs();
    logic [NUM_CH-1:0] inten;
    for (int i = 0; i < NUM_CH; i++) begin
      inten[i] = m_cntr[i][2];
      check($sformatf("dmadir[%0d]", i), 32'(dmadir[i]), 32'(m_cntr[i][1]));
      check($sformatf("preset[%0d]", i), 32'(preset[i]), 32'(m_cntr[i][4]));
      check($sformatf("dmaena[%0d]", i), 32'(dmaena[i]), 32'(m_dmaena[i]));
      check($sformatf("flush_fifo[%0d]", i), 32'(flush_fifo[i]), 32'(m_flush[i]));
      check($sformatf("a1[%0d]", i), 32'(a1[i]), 32'(m_a1[i]));
    end
    check("int_o_", 32'(int_o_), 32'(~|(m_int_p & inten)));
  endtask

  // Comparing process on falling edges
  always @(negedge ACR_WR) begin
    if (RST_ && !dsack_ && dsack_prev) check("mod", mod, exp_mod);  // dsack_ just fell
    if (out_done != out_req) begin
      check_outputs();
      out_done = out_req;
    end
    dsack_prev = dsack_;
  end

  task automatic request_output_check();
    int n;
    out_req++;
    n = 0;
    while (out_done != out_req && n < 4) begin
      @(negedge ACR_WR);
      n++;
    end
    if (out_done != out_req) begin
      err_other++;
      $display("output check was not serviced");
    end
  endtask

  // One CPU cycle where cs low keeps sel_ high and hold keeps as_ low after dsack_
  task automatic bus_cycle(input int ch, input int ofs, input bit rd, input logic [31:0] d,
                           input bit cs, input int hold);
    int n;
    @(negedge ACR_WR);
    exp_mod = rd ? ref_read(ch, ofs) : 32'h0;
    if (cs) update_model(ch, ofs, rd, d);
    addr = {3'(ch), 3'(ofs), 2'b00};
    rw   = rd;
    mid  = d;
    sel_ = ~cs;
    as_  = 1'b0;
    n = 0;
    while (dsack_ && n < ACK_LIMIT) begin
      @(negedge ACR_WR);
      n++;
    end
    if (cs && dsack_) begin
      err_other++;
      $display("dsack_ never asserted for channel %0d offset %0d", ch, ofs);
    end else if (!cs && !dsack_) begin
      err_other++;
      $display("dsack_ asserted for a cycle with sel_ high");
    end
    n = 0;
    while (n < hold) begin  // Slow CPU, termination must hold
      @(negedge ACR_WR);
      n++;
      if (cs && dsack_) begin
        err_other++;
        $display("dsack_ released while as_ was still low");
      end
    end
    as_  = 1'b1;
    sel_ = 1'b1;
    n = 0;
    while (!dsack_ && n < ACK_LIMIT) begin
      @(negedge ACR_WR);
      n++;
    end
    if (!dsack_) begin
      err_other++;
      $display("dsack_ stuck low after as_ was released");
    end
    request_output_check();
  endtask

  task automatic bus_write(input int ch, input int ofs, input logic [31:0] d);
    bus_cycle(ch, ofs, 1'b0, d, 1'b1, 0);
  endtask

  task automatic bus_read(input int ch, input int ofs);
    bus_cycle(ch, ofs, 1'b1, 32'h0, 1'b1, 0);
  endtask

  task automatic read_all(input int ofs);
    for (int c = 0; c < NUM_CH; c++) bus_read(c, ofs);
  endtask

  task automatic pulse_inta(input int ch);
    @(negedge ACR_WR);
    inta_i[ch]  = 1'b1;
    m_int_p[ch] = 1'b1;
    @(negedge ACR_WR);
    inta_i[ch] = 1'b0;
    request_output_check();
  endtask

  task automatic pulse_stop(input int ch);
    @(negedge ACR_WR);
    stop_flush[ch] = 1'b1;
    m_flush[ch]    = 1'b0;  // Stop wins over a pending flush
    @(negedge ACR_WR);
    stop_flush[ch] = 1'b0;
    request_output_check();
  endtask

  initial begin
    int          ch;
    logic [31:0] d;
    bit          rd_dir;
    lfsr = 32'h3e81;
    RST_ = 1'b0;
    addr = '0;
    sel_ = 1'b1;
    as_  = 1'b1;
    rw   = 1'b1;
    mid  = '0;
    inta_i     = '0;
    stop_flush = '0;
    fifo_empty = NUM_CH'(rand_bits(NUM_CH));
    fifo_full  = NUM_CH'(rand_bits(NUM_CH));
    for (int i = 0; i < NUM_CH; i++) m_cntr[i] = '0;
    m_dmaena  = '0;
    m_int_p   = '0;
    m_flush   = '0;
    m_a1      = '0;
    exp_mod   = '0;
    out_req   = 0;
    err_other = 0;
    repeat (3) @(negedge ACR_WR);
    RST_ = 1'b1;

    check("dsack_", 32'(dsack_), 32'h1);  // Bus side idle
    check("mod", mod, 32'h0);
    request_output_check();  // Reset values
    read_all(0);
    read_all(1);
    read_all(2);

    for (int c = 0; c < NUM_CH; c++) begin
      d = rand_bits(1);
      rd_dir = d[0];
      bus_cycle(c, 4, rd_dir, rand_bits(32), 1'b1, 0);  // ST_DMA
      read_all(1);
      if (c % 2 == 0) begin
        bus_cycle(c, 5, ~rd_dir, rand_bits(32), 1'b1, 2);  // SP_DMA in the other direction
        read_all(1);
      end
    end

    repeat (8) begin
      ch = int'(rand_bits(2));
      bus_write(ch, 1, rand_bits(32));
      read_all(1);
    end

    bus_write(0, 1, 32'h04);  // INTEN only
    bus_write(1, 1, 32'h06);
    bus_write(2, 1, 32'h00);
    pulse_inta(0);
    bus_read(0, 2);
    pulse_inta(1);
    bus_write(0, 6, rand_bits(32));  // Ch1 still holds int_o_ low
    bus_read(0, 2);
    bus_read(1, 6);                  // Clear through a read
    @(negedge ACR_WR);
    inta_i[2]  = 1'b1;               // Held high through the status read
    m_int_p[2] = 1'b1;               // Latched but masked
    bus_read(2, 2);
    inta_i[2] = 1'b0;
    bus_write(2, 6, 32'h0);

    bus_write(3, 7, rand_bits(32));
    bus_read(1, 7);
    pulse_stop(3);
    pulse_stop(1);
    bus_write(2, 3, rand_bits(32) | 32'h0200_0000);
    bus_write(0, 3, 32'h0200_0000);
    bus_write(2, 3, rand_bits(32) & ~32'h0200_0000);
    bus_read(0, 3);

    bus_cycle(1, 1, 1'b0, 32'hFF, 1'b0, 0);  // sel_ high so no termination
    bus_cycle(0, 4, 1'b1, 32'h0, 1'b0, 0);
    bus_cycle(3, 7, 1'b0, 32'h0, 1'b0, 0);
    bus_write(5, 1, 32'hFF);              // No such channel
    bus_write(4, 4, 32'h0);
    bus_read(6, 1);
    bus_write(7, 7, 32'h0);
    bus_write(0, 0, 32'hFFFF_FFFF);       // Unpaired write
    bus_write(1, 2, 32'hFFFF_FFFF);
    read_all(1);
    @(negedge ACR_WR);
    fifo_empty = NUM_CH'(rand_bits(NUM_CH));
    fifo_full  = NUM_CH'(rand_bits(NUM_CH));
    read_all(2);

    $display("checks %0d, value errors %0d, other errors %0d", n_checks, err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
src/sdmac_bus_pkg.sv
src/sdmac_chan_pkg.sv
src/sdmac_addr_decoder.sv
src/sdmac_channel_regs.sv
src/sdmac_bus_return.sv
src/sdmac_registers.sv
testbench/sdmac_registers_asserts.sv
testbench/tb_sdmac_registers.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_sdmac_registers
FILELIST  := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Output goes to the terminal and is searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
